// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --top-module cpu_tb -f cpu.f -o cpu_sim
	./obj_dir/cpu_sim | tee /dev/stderr | grep -q "Finished with no errors"

clean:
	rm -rf obj_dir

// File: cpu.f
verilog/configure.sv
verilog/issue_unit.sv
verilog/alu.sv
verilog/register.sv
verilog/cpu.sv
verification/cpu_tb.sv

// File: verification/cpu_tb.sv
`timescale 1ns/1ps

module cpu_tb;

  typedef logic [configure::NUM_LANES-1:0][31:0] bundle_t;
  typedef logic [configure::REG_COUNT-1:0][configure::XLEN-1:0] model_regs_t;
  // kind 0 is a register word, 1 a status word, 2 a pslverr bit and 3 the busy output
  typedef struct packed {
    logic [1:0]                 kind;
    logic [configure::XLEN-1:0] got;
    logic [configure::XLEN-1:0] exp;
  } cmp_item_t;

  localparam int timeout_cycles = 200;

  logic clock = 1'b0;
  logic arst_n;
  configure::apb_req_t apb_req;
  configure::apb_rsp_t apb_rsp;
  logic busy;

  model_regs_t model;
  cmp_item_t cmp_q [$];
  string tag_q [$];
  int errors = 0;

  cpu UUT (
    .clock  (clock),
    .arst_n (arst_n),
    .apb_req(apb_req),
    .apb_rsp(apb_rsp),
    .busy   (busy)
  );

  always #5 clock = ~clock;

  function automatic logic legal_word(input logic [31:0] w);
    logic [6:0] f7;
    f7 = w[31:25];
    if (w[6:0] == 7'b0110011)
      return f7 == 7'h00 || (f7 == 7'h20 && (w[14:12] == 3'b000 || w[14:12] == 3'b101));
    if (w[6:0] == 7'b0010011) begin
      if (w[14:12] == 3'b001) return f7 == 7'h00;
      if (w[14:12] == 3'b101) return f7 == 7'h00 || f7 == 7'h20;
      return 1'b1;
    end
    return 1'b0;
  endfunction

  // lanes apply in order, so a later lane sees an earlier lane's result
  function automatic model_regs_t model_bundle(input bundle_t b, input model_regs_t m);
    logic [31:0] w;
    logic [31:0] a;
    logic [31:0] op_b;
    logic [31:0] r;
    logic alt;
    for (int k = 0; k < configure::NUM_LANES; k++) begin
      w = b[k];
      if (legal_word(w)) begin
        a = m[w[19:15]];
        op_b = (w[6:0] == 7'b0110011) ? m[w[24:20]] : {{20{w[31]}}, w[31:20]};
        alt = w[30] && (w[6:0] == 7'b0110011 || w[14:12] == 3'b101);
        case (w[14:12])
          3'b000: r = alt ? a - op_b : a + op_b;
          3'b001: r = a << op_b[4:0];
          3'b010: r = {31'b0, $signed(a) < $signed(op_b)};
          3'b011: r = {31'b0, a < op_b};
          3'b100: r = a ^ op_b;
          3'b101: begin
            if (alt) r = $signed(a) >>> op_b[4:0];
            else r = a >> op_b[4:0];
          end
          3'b110: r = a | op_b;
          default: r = a & op_b;
        endcase
        if (w[11:7] != 5'd0) m[w[11:7]] = r;
      end
    end
    return m;
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, 7'b0010011};
  endfunction

  // sel 0 to 9 are the R forms, 10 to 19 the I forms, where 11 falls back to ADDI
  function automatic logic [31:0] rand_instr(input int sel, input logic [4:0] rd,
                                             input logic [4:0] rs1, input logic [4:0] rs2);
    logic [11:0] imm;
    logic [2:0] f3;
    logic [6:0] f7;
    imm = 12'($urandom);
    case (sel % 10)
      0, 1: f3 = 3'b000;
      2: f3 = 3'b111;
      3: f3 = 3'b110;
      4: f3 = 3'b100;
      5: f3 = 3'b001;
      6, 7: f3 = 3'b101;
      8: f3 = 3'b010;
      default: f3 = 3'b011;
    endcase
    f7 = (sel % 10 == 1 || sel % 10 == 7) ? 7'h20 : 7'h00;
    if (sel < 10) return enc_r(f7, rs2, rs1, f3, rd);
    // immediate shifts carry funct7 in the upper immediate bits
    if (f3 == 3'b001 || f3 == 3'b101) imm = {f7, imm[4:0]};
    return enc_i(imm, rs1, f3, rd);
  endfunction

  task automatic timeout_fail(input string what);
    $display("Timed out waiting for %s", what);
    $display("errors: %0d, timeouts: 1", errors);
    $display("Finished with errors");
    $finish;
  endtask

  task automatic check_word(input logic [configure::XLEN-1:0] got,
                            input logic [configure::XLEN-1:0] exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t ns: %s read %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_status(input logic [configure::XLEN-1:0] got,
                              input logic [configure::XLEN-1:0] exp, input string what);
    if (got[configure::status_busy_bit] !== exp[configure::status_busy_bit] ||
        got[configure::status_illegal_bit] !== exp[configure::status_illegal_bit]) begin
      errors++;
      $display("MISMATCH at %0t ns: %s status %b, expected %b", $time, what,
               got[1:0], exp[1:0]);
    end
  endtask

  task automatic check_slverr(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t ns: %s pslverr %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_busy(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t ns: %s busy %b, expected %b", $time, what, got, exp);
    end
  endtask

  always @(negedge clock) begin
    cmp_item_t item;
    string tag;
    while (cmp_q.size() != 0) begin
      item = cmp_q.pop_front();
      tag = tag_q.pop_front();
      case (item.kind)
        2'd0: check_word(item.got, item.exp, tag);
        2'd1: check_status(item.got, item.exp, tag);
        2'd2: check_slverr(item.got[0], item.exp[0], tag);
        default: check_busy(item.got[0], item.exp[0], tag);
      endcase
    end
  end

  task automatic expect_item(input logic [1:0] kind, input logic [31:0] got,
                             input logic [31:0] exp, input string tag);
    cmp_q.push_back('{kind, got, exp});
    tag_q.push_back(tag);
  endtask

  // setup phase, then access phase held until pready is seen high
  task automatic apb_xfer(input logic write, input logic [11:0] addr, input logic [31:0] wdata,
                          output logic [31:0] rdata, output logic slverr);
    int cnt;
    @(posedge clock);
    #1;
    apb_req.psel = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite = write;
    apb_req.paddr = addr;
    apb_req.pwdata = wdata;
    @(posedge clock);
    #1;
    apb_req.penable = 1'b1;
    cnt = 0;
    @(negedge clock);
    while (!apb_rsp.pready) begin
      if (cnt == timeout_cycles) timeout_fail("an APB transfer to complete");
      cnt++;
      @(negedge clock);
    end
    rdata = apb_rsp.prdata;
    slverr = apb_rsp.pslverr;
    @(posedge clock);
    #1;
    apb_req.psel = 1'b0;
    apb_req.penable = 1'b0;
  endtask

  task automatic wait_idle();
    int cnt;
    cnt = 0;
    @(negedge clock);
    while (busy) begin
      if (cnt == timeout_cycles) timeout_fail("the bundle to finish");
      cnt++;
      @(negedge clock);
    end
  endtask

  task automatic run_bundle(input bundle_t b);
    logic [31:0] rdata;
    logic err;
    logic any_legal;
    any_legal = 1'b0;
    for (int k = 0; k < configure::NUM_LANES; k++) begin
      apb_xfer(1'b1, configure::SLOT_BASE + 12'(4 * k), b[k], rdata, err);
      any_legal = any_legal || legal_word(b[k]);
    end
    apb_xfer(1'b1, configure::ISSUE_ADDR, '0, rdata, err);
    // a bundle with a legal lane holds busy from the issue edge on
    expect_item(2'd3, 32'(busy), 32'(any_legal), "after issue");
    wait_idle();
    model = model_bundle(b, model);
  endtask

  task automatic read_all_regs();
    logic [31:0] rdata;
    logic err;
    for (int r = 0; r < configure::REG_COUNT; r++) begin
      apb_xfer(1'b0, configure::REG_BASE + 12'(4 * r), '0, rdata, err);
      expect_item(2'd0, rdata, model[r], $sformatf("x%0d", r));
      expect_item(2'd2, 32'(err), 32'd0, $sformatf("read of x%0d", r));
    end
  endtask

  task automatic read_status(input logic illegal_exp, input string tag);
    logic [31:0] rdata;
    logic err;
    logic [31:0] exp;
    exp = '0;
    exp[configure::status_illegal_bit] = illegal_exp;
    apb_xfer(1'b0, configure::STATUS_ADDR, '0, rdata, err);
    expect_item(2'd1, rdata, exp, tag);
  endtask

  task automatic drain_checks();
    int cnt;
    cnt = 0;
    while (cmp_q.size() != 0) begin
      if (cnt == timeout_cycles) timeout_fail("the comparison queue to drain");
      cnt++;
      @(posedge clock);
    end
  endtask

  initial begin
    logic [31:0] rdata;
    logic err;
    bundle_t b;
    logic [4:0] rd0;
    logic [4:0] rs1;
    logic [4:0] rs2;
    void'($urandom(46331));
    arst_n = 1'b0;
    apb_req = '0;
    model = '0;
    repeat (8) @(posedge clock);
    #1;
    arst_n = 1'b1;

    read_all_regs();
    read_status(1'b0, "after reset");

    // every register gets a wide random value from ADDI and SLLI chains
    for (int r = 1; r < configure::REG_COUNT; r++) begin
      b[0] = enc_i(12'($urandom), 5'd0, 3'b000, 5'(r));
      b[1] = enc_i(12'd11, 5'(r), 3'b001, 5'(r));
      run_bundle(b);
      b[0] = enc_i(12'($urandom), 5'(r), 3'b000, 5'(r));
      b[1] = enc_i(12'd9, 5'(r), 3'b001, 5'(r));
      run_bundle(b);
    end
    read_all_regs();

    // independent bundles, with lane 1 kept off lane 0's destination
    for (int n = 0; n < 60; n++) begin
      rd0 = 5'($urandom);
      b[0] = rand_instr(n % 20, rd0, 5'($urandom), 5'($urandom));
      rs1 = 5'($urandom);
      rs2 = 5'($urandom);
      if (rs1 == rd0) rs1 = rd0 ^ 5'd1;
      if (rs2 == rd0) rs2 = rd0 ^ 5'd1;
      b[1] = rand_instr(int'($urandom % 20), 5'($urandom), rs1, rs2);
      run_bundle(b);
    end
    read_all_regs();

    // lane 1 reads lane 0's result through rs1 or through rs2
    for (int n = 0; n < 20; n++) begin
      rd0 = 5'(1 + $urandom % 31);
      b[0] = rand_instr(n, rd0, 5'($urandom), 5'($urandom));
      if (n[0]) b[1] = rand_instr((n * 3) % 10, 5'($urandom), 5'($urandom), rd0);
      else b[1] = rand_instr(10 + n % 10, 5'($urandom), rd0, 5'($urandom));
      run_bundle(b);
    end
    read_all_regs();

    b[0] = enc_i(12'h07b, 5'd0, 3'b000, 5'd5);
    b[1] = enc_i(12'hff9, 5'd0, 3'b000, 5'd5);
    run_bundle(b);
    b[0] = enc_i(12'h123, 5'd3, 3'b000, 5'd0);
    b[1] = enc_r(7'h00, 5'd4, 5'd3, 3'b000, 5'd0);
    run_bundle(b);
    read_all_regs();

    // a load opcode in lane 0
    b[0] = {12'h000, 5'd1, 3'b010, 5'd8, 7'b0000011};
    b[1] = enc_i(12'h001, 5'd8, 3'b000, 5'd9);
    run_bundle(b);
    read_status(1'b1, "illegal opcode");
    apb_xfer(1'b1, configure::STATUS_ADDR, 32'h2, rdata, err);
    read_status(1'b0, "illegal flag cleared");
    // funct7 of a multiply is unsupported
    b[0] = enc_r(7'h01, 5'd2, 5'd1, 3'b000, 5'd10);
    b[1] = enc_i(12'h7ff, 5'd10, 3'b000, 5'd11);
    run_bundle(b);
    read_status(1'b1, "illegal funct7");
    apb_xfer(1'b1, configure::STATUS_ADDR, 32'h2, rdata, err);
    read_status(1'b0, "illegal flag cleared again");

    apb_xfer(1'b0, 12'h080, '0, rdata, err);
    expect_item(2'd2, 32'(err), 32'd1, "read of unmapped 0x080");
    expect_item(2'd0, rdata, '0, "data of unmapped 0x080");
    apb_xfer(1'b1, 12'h088, 32'hffff_ffff, rdata, err);
    expect_item(2'd2, 32'(err), 32'd1, "write of unmapped 0x088");
    read_all_regs();
    read_status(1'b0, "end of run");

    drain_checks();
    $display("errors: %0d, timeouts: 0", errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// File: verilog/alu.sv
`timescale 1ns/1ps

module alu (
  input  logic                 clock,
  input  logic                 arst_n,
  input  configure::lane_req_t req,
  output configure::lane_res_t res
);

  logic [configure::XLEN-1:0] result;
  logic [4:0] shamt;
  logic valid_q;
  logic [configure::REG_ADDR_W-1:0] rd_q;
  logic [configure::XLEN-1:0] value_q;

  assign shamt = req.operand_b[4:0];

  always_comb begin
    case (req.op)
      configure::alu_add: result = req.operand_a + req.operand_b;
      configure::alu_sub: result = req.operand_a - req.operand_b;
      configure::alu_and: result = req.operand_a & req.operand_b;
      configure::alu_or: result = req.operand_a | req.operand_b;
      configure::alu_xor: result = req.operand_a ^ req.operand_b;
      configure::alu_sll: result = req.operand_a << shamt;
      configure::alu_srl: result = req.operand_a >> shamt;
      configure::alu_sra: result = $signed(req.operand_a) >>> shamt;
      configure::alu_slt:
        result = {{(configure::XLEN - 1){1'b0}},
                  $signed(req.operand_a) < $signed(req.operand_b)};
      configure::alu_sltu:
        result = {{(configure::XLEN - 1){1'b0}}, req.operand_a < req.operand_b};
      default: result = req.operand_a + req.operand_b;
    endcase
  end

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= req.valid;
    end
  end

  // result only moves when a request arrives
  always_ff @(posedge clock) begin
    if (req.valid) begin
      rd_q <= req.rd;
      value_q <= result;
    end
  end

  assign res.valid = valid_q;
  assign res.rd = rd_q;
  assign res.value = value_q;

endmodule

// File: verilog/configure.sv
package configure;

  localparam int NUM_LANES = 2;
  localparam int XLEN = 32;
  localparam int REG_COUNT = 32;
  localparam int REG_ADDR_W = 5;
  localparam int APB_ADDR_W = 12;

  localparam logic [APB_ADDR_W-1:0] SLOT_BASE = 12'h000;
  localparam logic [APB_ADDR_W-1:0] ISSUE_ADDR = 12'h040;
  localparam logic [APB_ADDR_W-1:0] STATUS_ADDR = 12'h044;
  localparam logic [APB_ADDR_W-1:0] REG_BASE = 12'h100;

  // bit positions inside the status word
  localparam int status_busy_bit = 0;
  localparam int status_illegal_bit = 1;

  localparam logic [6:0] opcode_op = 7'b0110011;
  localparam logic [6:0] opcode_op_imm = 7'b0010011;
  // selects SUB and SRA in the R form, SRAI in the I form
  localparam logic [6:0] funct7_alt = 7'b0100000;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_type_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_type_t;

  // the immediate shifts need both views of the same word
  typedef union packed {
    r_type_t r;
    i_type_t i;
  } instr_word_t;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_sll,
    alu_srl,
    alu_sra,
    alu_slt,
    alu_sltu
  } alu_op_t;

  typedef struct packed {
    logic                  valid;
    alu_op_t               op;
    logic [XLEN-1:0]       operand_a;
    logic [XLEN-1:0]       operand_b;
    logic [REG_ADDR_W-1:0] rd;
  } lane_req_t;

  typedef struct packed {
    logic                  valid;
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       value;
  } lane_res_t;

  typedef struct packed {
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [APB_ADDR_W-1:0] paddr;
    logic [XLEN-1:0]       pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [XLEN-1:0] prdata;
    logic            pready;
    logic            pslverr;
  } apb_rsp_t;

endpackage

// File: verilog/cpu.sv
`timescale 1ns/1ps

module cpu (
  input  logic                clock,
  input  logic                arst_n,
  input  configure::apb_req_t apb_req,
  output configure::apb_rsp_t apb_rsp,
  output logic                busy
);

  configure::lane_req_t lane_req [configure::NUM_LANES];
  configure::lane_res_t lane_res [configure::NUM_LANES];
  logic [configure::REG_ADDR_W-1:0] rs_addr [configure::NUM_LANES][2];
  logic [configure::XLEN-1:0] rs_data [configure::NUM_LANES][2];
  logic [configure::REG_ADDR_W-1:0] host_addr;
  logic [configure::XLEN-1:0] host_data;

  issue_unit issue_unit_comp (
    .clock    (clock),
    .arst_n   (arst_n),
    .apb_req  (apb_req),
    .apb_rsp  (apb_rsp),
    .lane_req (lane_req),
    .rs_addr  (rs_addr),
    .rs_data  (rs_data),
    .host_addr(host_addr),
    .host_data(host_data),
    .busy     (busy)
  );

  for (genvar k = 0; k < configure::NUM_LANES; k++) begin : g_lane
    alu alu_comp (
      .clock (clock),
      .arst_n(arst_n),
      .req   (lane_req[k]),
      .res   (lane_res[k])
    );
  end

  register register_comp (
    .clock    (clock),
    .arst_n   (arst_n),
    .res      (lane_res),
    .rs_addr  (rs_addr),
    .rs_data  (rs_data),
    .host_addr(host_addr),
    .host_data(host_data)
  );

endmodule

// File: verilog/issue_unit.sv
`timescale 1ns/1ps

module issue_unit (
  input  logic                             clock,
  input  logic                             arst_n,
  input  configure::apb_req_t              apb_req,
  output configure::apb_rsp_t              apb_rsp,
  output configure::lane_req_t             lane_req [configure::NUM_LANES],
  output logic [configure::REG_ADDR_W-1:0] rs_addr [configure::NUM_LANES][2],
  input  logic [configure::XLEN-1:0]       rs_data [configure::NUM_LANES][2],
  output logic [configure::REG_ADDR_W-1:0] host_addr,
  input  logic [configure::XLEN-1:0]       host_data,
  output logic                             busy
);

  configure::instr_word_t slot [configure::NUM_LANES];

  configure::alu_op_t dec_op [configure::NUM_LANES];
  logic [configure::NUM_LANES-1:0] dec_legal;

  // decoded bundle, captured when the issue command completes
  configure::alu_op_t bnd_op [configure::NUM_LANES];
  logic [configure::REG_ADDR_W-1:0] bnd_rd [configure::NUM_LANES];
  logic [configure::REG_ADDR_W-1:0] bnd_rs1 [configure::NUM_LANES];
  logic [configure::REG_ADDR_W-1:0] bnd_rs2 [configure::NUM_LANES];
  logic [configure::XLEN-1:0] bnd_imm [configure::NUM_LANES];
  logic [configure::NUM_LANES-1:0] bnd_use_imm;

  logic [configure::NUM_LANES-1:0] pending;
  logic [configure::NUM_LANES-1:0] in_flight;
  logic [configure::NUM_LANES-1:0] fire;
  logic illegal;

  logic access;
  logic pready;
  logic mapped;
  logic hit_issue;
  logic hit_status;
  logic hit_reg;
  logic issue_go;
  logic [configure::NUM_LANES-1:0] hit_slot;

  function automatic configure::alu_op_t f3_op(input logic [2:0] funct3, input logic alt);
    case (funct3)
      3'b000: return alt ? configure::alu_sub : configure::alu_add;
      3'b001: return configure::alu_sll;
      3'b010: return configure::alu_slt;
      3'b011: return configure::alu_sltu;
      3'b100: return configure::alu_xor;
      3'b101: return alt ? configure::alu_sra : configure::alu_srl;
      3'b110: return configure::alu_or;
      default: return configure::alu_and;
    endcase
  endfunction

  function automatic logic is_legal(input configure::instr_word_t w);
    logic alt;
    logic zero;
    alt = w.r.funct7 == configure::funct7_alt;
    zero = w.r.funct7 == '0;
    if (w.r.opcode == configure::opcode_op)
      return zero || (alt && (w.r.funct3 == 3'b000 || w.r.funct3 == 3'b101));
    if (w.i.opcode == configure::opcode_op_imm) begin
      // upper immediate bits of a shift are a funct7 field
      if (w.i.funct3 == 3'b001) return zero;
      if (w.i.funct3 == 3'b101) return zero || alt;
      return 1'b1;
    end
    return 1'b0;
  endfunction

  always_comb begin
    for (int k = 0; k < configure::NUM_LANES; k++) begin
      dec_legal[k] = is_legal(slot[k]);
      if (slot[k].r.opcode == configure::opcode_op)
        dec_op[k] = f3_op(slot[k].r.funct3, slot[k].r.funct7 == configure::funct7_alt);
      else
        dec_op[k] = f3_op(slot[k].i.funct3, slot[k].i.funct3 == 3'b101 &&
                          slot[k].r.funct7 == configure::funct7_alt);
    end
  end

  always_comb begin
    for (int k = 0; k < configure::NUM_LANES; k++) begin
      hit_slot[k] = apb_req.paddr == configure::SLOT_BASE + configure::APB_ADDR_W'(4 * k);
    end
    hit_issue = apb_req.paddr == configure::ISSUE_ADDR;
    hit_status = apb_req.paddr == configure::STATUS_ADDR;
    hit_reg = apb_req.paddr[configure::APB_ADDR_W-1:configure::REG_ADDR_W+2] ==
              configure::REG_BASE[configure::APB_ADDR_W-1:configure::REG_ADDR_W+2] &&
              apb_req.paddr[1:0] == 2'b00;
    mapped = (|hit_slot) || hit_issue || hit_status || hit_reg;
  end

  assign host_addr = apb_req.paddr[2 +: configure::REG_ADDR_W];
  assign access = apb_req.psel && apb_req.penable;
  // issue commands and register reads wait for the running bundle
  assign pready = !(apb_req.psel && busy &&
                    ((hit_issue && apb_req.pwrite) || (hit_reg && !apb_req.pwrite)));
  assign issue_go = access && pready && apb_req.pwrite && hit_issue;
  assign busy = (|pending) || (|in_flight);

  always_comb begin
    apb_rsp.pready = pready;
    apb_rsp.pslverr = access && !mapped;
    apb_rsp.prdata = '0;
    if (!apb_req.pwrite) begin
      if (hit_status) begin
        apb_rsp.prdata[configure::status_busy_bit] = busy;
        apb_rsp.prdata[configure::status_illegal_bit] = illegal;
      end
      if (hit_reg) apb_rsp.prdata = host_data;
      for (int k = 0; k < configure::NUM_LANES; k++) begin
        if (hit_slot[k]) apb_rsp.prdata = slot[k];
      end
    end
  end

  always_ff @(posedge clock) begin
    for (int k = 0; k < configure::NUM_LANES; k++) begin
      if (access && apb_req.pwrite && hit_slot[k]) slot[k] <= apb_req.pwdata;
    end
  end

  always_ff @(posedge clock) begin
    if (issue_go) begin
      for (int k = 0; k < configure::NUM_LANES; k++) begin
        bnd_op[k] <= dec_op[k];
        bnd_rd[k] <= slot[k].r.rd;
        bnd_rs1[k] <= slot[k].r.rs1;
        bnd_rs2[k] <= slot[k].r.rs2;
        bnd_imm[k] <= {{(configure::XLEN - 12){slot[k].i.imm[11]}}, slot[k].i.imm};
        bnd_use_imm[k] <= slot[k].i.opcode == configure::opcode_op_imm;
      end
    end
  end

  // lanes issue in order, and a lane reading an unwritten earlier rd waits
  always_comb begin
    logic order_ok;
    logic raw;
    order_ok = 1'b1;
    for (int k = 0; k < configure::NUM_LANES; k++) begin
      raw = 1'b0;
      for (int j = 0; j < k; j++) begin
        if ((pending[j] || in_flight[j]) && bnd_rd[j] != '0 &&
            (bnd_rs1[k] == bnd_rd[j] || (!bnd_use_imm[k] && bnd_rs2[k] == bnd_rd[j])))
          raw = 1'b1;
      end
      fire[k] = pending[k] && !raw && order_ok;
      order_ok = order_ok && (!pending[k] || fire[k]);
    end
  end

  always_comb begin
    for (int k = 0; k < configure::NUM_LANES; k++) begin
      rs_addr[k][0] = bnd_rs1[k];
      rs_addr[k][1] = bnd_rs2[k];
      lane_req[k].valid = fire[k];
      lane_req[k].op = bnd_op[k];
      lane_req[k].operand_a = rs_data[k][0];
      lane_req[k].operand_b = bnd_use_imm[k] ? bnd_imm[k] : rs_data[k][1];
      lane_req[k].rd = bnd_rd[k];
    end
  end

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      pending <= '0;
      in_flight <= '0;
      illegal <= 1'b0;
    end else begin
      in_flight <= fire;
      // illegal slots never become pending, so they act as no-ops
      if (issue_go) pending <= dec_legal;
      else pending <= pending & ~fire;
      if (access && apb_req.pwrite && hit_status &&
          apb_req.pwdata[configure::status_illegal_bit])
        illegal <= 1'b0;
      else if (issue_go && !(&dec_legal))
        illegal <= 1'b1;
    end
  end

endmodule

// File: verilog/register.sv
`timescale 1ns/1ps

module register (
  input  logic                             clock,
  input  logic                             arst_n,
  input  configure::lane_res_t             res [configure::NUM_LANES],
  input  logic [configure::REG_ADDR_W-1:0] rs_addr [configure::NUM_LANES][2],
  output logic [configure::XLEN-1:0]       rs_data [configure::NUM_LANES][2],
  input  logic [configure::REG_ADDR_W-1:0] host_addr,
  output logic [configure::XLEN-1:0]       host_data
);

  logic [configure::XLEN-1:0] regs [configure::REG_COUNT];

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < configure::REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else begin
      // a higher lane is later in program order, so its write lands last
      for (int k = 0; k < configure::NUM_LANES; k++) begin
        if (res[k].valid && res[k].rd != '0) begin
          regs[res[k].rd] <= res[k].value;
        end
      end
    end
  end

  always_comb begin
    for (int k = 0; k < configure::NUM_LANES; k++) begin
      for (int p = 0; p < 2; p++) begin
        rs_data[k][p] = (rs_addr[k][p] == '0) ? '0 : regs[rs_addr[k][p]];
      end
    end
  end

  // x0 is hardwired to zero
  assign host_data = (host_addr == '0) ? '0 : regs[host_addr];

endmodule
